/* src/video_defines.svh */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// line geometry
`define LINE_PIXELS    64
`define PIX_PER_WORD   4
`define WORDS_PER_LINE 16
`define TILE_PIXELS    8
`define TILES_PER_LINE 8

// bus widths
`define DRAM_AW 20
`define DRAM_DW 16
`define CFG_AW  3
`define COLOR_W 8

`endif

/* src/video_cfg_pkg.sv */
`include "video_defines.svh"

package video_cfg_pkg;

  // cpu register map, unlisted addresses fall through
  typedef enum logic [`CFG_AW-1:0] {
    VCONF  = 3'd0,
    BORDER = 3'd1,
    PALSEL = 3'd2,
    VPAGE  = 3'd3,
    TMPAGE = 3'd4,
    TGPAGE = 3'd5
  } cfg_reg_e;

  // settings frozen for one line
  typedef struct packed {
    logic                gfx_en;
    logic                tile_en;
    logic [`COLOR_W-1:0] border;
    logic [7:0]          palsel;
    logic [7:0]          vpage;
    logic [7:0]          tmpage;
    logic [7:0]          tgpage;
  } video_cfg_t;

endpackage

/* src/video_mem_pkg.sv */
`include "video_defines.svh"

package video_mem_pkg;

  // four 4bpp pixels, element 0 sits in the top nibble and is leftmost
  typedef struct packed {
    logic [0:`PIX_PER_WORD-1][3:0] pix;
  } bitmap_word_t;

  // tile map entry, tile number in the low byte
  typedef struct packed {
    logic [3:0] rsvd;
    logic       yflip;
    logic       xflip;
    logic [1:0] pal;
    logic [7:0] tnum;
  } tile_entry_t;

  // same read data, decoded per the fetch it answers
  typedef union packed {
    bitmap_word_t bmp;
    tile_entry_t  ent;
  } dram_word_u;

  // owner of the shared dram port
  typedef enum logic {GFX, TILE} client_e;

endpackage

/* src/dram_client_if.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

interface dram_client_if;

  logic                req_valid;
  logic                req_ready;
  logic [`DRAM_AW-1:0] addr;
  // single pulse per read, no stall
  logic                rvalid;
  logic [`DRAM_DW-1:0] rdata;

  modport client  (output req_valid, output addr, input req_ready, input rvalid, input rdata);
  modport arbiter (input req_valid, input addr, output req_ready, output rvalid, output rdata);

endinterface

/* src/video_ports.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_ports import video_cfg_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfg_wr,
  input  logic [`CFG_AW-1:0] cfg_addr,
  input  logic [7:0]         cfg_data,
  input  logic               line_accept,
  output video_cfg_t         line_cfg
);

  // registers as the cpu sees them
  video_cfg_t live;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      live     <= '0;
      line_cfg <= '0;
    end
    else
    begin
      if (cfg_wr)
      begin
        case (cfg_reg_e'(cfg_addr))
          VCONF:
          begin
            // layer enables in the two low bits
            live.gfx_en  <= cfg_data[0];
            live.tile_en <= cfg_data[1];
          end
          BORDER:  live.border <= cfg_data;
          PALSEL:  live.palsel <= cfg_data;
          VPAGE:   live.vpage  <= cfg_data;
          TMPAGE:  live.tmpage <= cfg_data;
          TGPAGE:  live.tgpage <= cfg_data;
          default: ;
        endcase
      end
      // shadow copy for the line just taken
      if (line_accept)
        line_cfg <= live;
    end
  end

endmodule

/* src/dram_arbiter.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module dram_arbiter import video_mem_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  dram_client_if.arbiter      gfx,
  dram_client_if.arbiter      tile,
  output logic                dram_valid,
  input  logic                dram_ready,
  output logic [`DRAM_AW-1:0] dram_addr,
  input  logic                dram_rvalid,
  input  logic [`DRAM_DW-1:0] dram_rdata
);

  // last grant owner, also the one a response goes back to
  client_e owner;
  client_e sel;
  // read outstanding on the port
  logic    busy;
  // offered but not yet taken, selection frozen
  logic    hold;

  always_comb
  begin
    if (hold)
      sel = owner;
    else if (gfx.req_valid && tile.req_valid)
      sel = (owner == GFX) ? TILE : GFX;
    else if (tile.req_valid)
      sel = TILE;
    else
      sel = GFX;
  end

  assign dram_valid = !busy && ((sel == GFX) ? gfx.req_valid : tile.req_valid);
  assign dram_addr  = (sel == GFX) ? gfx.addr : tile.addr;

  assign gfx.req_ready  = !busy && (sel == GFX) && dram_ready;
  assign tile.req_ready = !busy && (sel == TILE) && dram_ready;

  // response only to the owner
  assign gfx.rvalid  = busy && (owner == GFX) && dram_rvalid;
  assign tile.rvalid = busy && (owner == TILE) && dram_rvalid;
  assign gfx.rdata   = dram_rdata;
  assign tile.rdata  = dram_rdata;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      owner <= GFX;
      busy  <= 1'b0;
      hold  <= 1'b0;
    end
    else
    begin
      if (dram_valid)
      begin
        owner <= sel;
        // taken now or stalled by the port
        busy  <= dram_ready;
        hold  <= !dram_ready;
      end
      if (busy && dram_rvalid)
        busy <= 1'b0;
    end
  end

endmodule

/* src/gfx_fetch.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module gfx_fetch import video_cfg_pkg::*, video_mem_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  dram_client_if.client       mem,
  input  video_cfg_t          line_cfg,
  input  logic                fill_start,
  input  logic [7:0]          fill_line,
  output logic                fill_done,
  output logic                gfx_we,
  output logic [5:0]          gfx_waddr,
  output logic [`COLOR_W-1:0] gfx_wdata
);

  typedef enum logic [1:0] {G_IDLE, G_REQ, G_WAIT, G_WRITE} gfx_state_e;

  gfx_state_e state;
  logic [3:0] word_idx;
  logic [1:0] pix_idx;
  dram_word_u word_q;

  // bitmap row: page, line, word
  assign mem.req_valid = (state == G_REQ);
  assign mem.addr      = {line_cfg.vpage, fill_line, word_idx};

  // one pixel per cycle, palette bank above the nibble
  assign gfx_we    = (state == G_WRITE);
  assign gfx_waddr = {word_idx, pix_idx};
  assign gfx_wdata = {line_cfg.palsel[3:0], word_q.bmp.pix[pix_idx]};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= G_IDLE;
      word_idx  <= '0;
      pix_idx   <= '0;
      fill_done <= 1'b0;
    end
    else
    begin
      fill_done <= 1'b0;
      case (state)
        G_IDLE:
        begin
          if (fill_start)
          begin
            word_idx <= '0;
            pix_idx  <= '0;
            // layer off, nothing to read
            if (line_cfg.gfx_en)
              state <= G_REQ;
            else
              fill_done <= 1'b1;
          end
        end
        G_REQ:
        begin
          if (mem.req_ready)
            state <= G_WAIT;
        end
        G_WAIT:
        begin
          if (mem.rvalid)
            state <= G_WRITE;
        end
        G_WRITE:
        begin
          pix_idx <= pix_idx + 2'd1;
          if (pix_idx == 2'(`PIX_PER_WORD - 1))
          begin
            word_idx <= word_idx + 4'd1;
            if (word_idx == 4'(`WORDS_PER_LINE - 1))
            begin
              state     <= G_IDLE;
              fill_done <= 1'b1;
            end
            else
              state <= G_REQ;
          end
        end
        default: state <= G_IDLE;
      endcase
    end
  end

  // read word kept for the write burst
  always_ff @(posedge clk)
  begin
    if ((state == G_WAIT) && mem.rvalid)
      word_q <= dram_word_u'(mem.rdata);
  end

endmodule

/* src/tile_fetch.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module tile_fetch import video_cfg_pkg::*, video_mem_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  dram_client_if.client       mem,
  input  video_cfg_t          line_cfg,
  input  logic                fill_start,
  input  logic [7:0]          fill_line,
  output logic                fill_done,
  output logic                tile_we,
  output logic [5:0]          tile_waddr,
  output logic [`COLOR_W-1:0] tile_wdata
);

  typedef enum logic [2:0] {
    T_IDLE,
    T_MAP_REQ,
    T_MAP_WAIT,
    T_ROW_REQ,
    T_ROW_WAIT,
    T_WRITE
  } tile_state_e;

  tile_state_e         state;
  logic [2:0]          tile_idx;
  // which 4-pixel half of the tile row
  logic                half;
  logic [1:0]          pix_idx;
  tile_entry_t         entry_q;
  bitmap_word_t        word_q;
  dram_word_u          rd_word;
  logic [2:0]          row;
  logic [2:0]          src_x;
  logic [2:0]          dst_x;
  logic [3:0]          nib;
  logic [`DRAM_AW-1:0] map_addr;
  logic [`DRAM_AW-1:0] row_addr;

  assign rd_word = dram_word_u'(mem.rdata);

  // y flip picks the mirrored row
  assign row      = fill_line[2:0] ^ {3{entry_q.yflip}};
  // map: page, tile row of the line, tile column
  assign map_addr = {line_cfg.tmpage, 4'd0, fill_line[7:3], tile_idx};
  // tile gfx: page, tile number, pixel row, half
  assign row_addr = {line_cfg.tgpage, entry_q.tnum, row, half};

  assign mem.req_valid = (state == T_MAP_REQ) || (state == T_ROW_REQ);
  assign mem.addr      = (state == T_MAP_REQ) ? map_addr : row_addr;

  // x flip mirrors the column inside the tile
  assign src_x = {half, pix_idx};
  assign dst_x = entry_q.xflip ? ~src_x : src_x;
  assign nib   = word_q.pix[pix_idx];

  assign tile_we    = (state == T_WRITE);
  assign tile_waddr = {tile_idx, dst_x};
  // nibble 0 stays transparent
  assign tile_wdata = (nib == 4'd0) ? '0 : {line_cfg.palsel[7:6], entry_q.pal, nib};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= T_IDLE;
      tile_idx  <= '0;
      half      <= 1'b0;
      pix_idx   <= '0;
      fill_done <= 1'b0;
    end
    else
    begin
      fill_done <= 1'b0;
      case (state)
        T_IDLE:
        begin
          if (fill_start)
          begin
            tile_idx <= '0;
            half     <= 1'b0;
            pix_idx  <= '0;
            if (line_cfg.tile_en)
              state <= T_MAP_REQ;
            else
              fill_done <= 1'b1;
          end
        end
        T_MAP_REQ:  if (mem.req_ready) state <= T_MAP_WAIT;
        T_MAP_WAIT: if (mem.rvalid) state <= T_ROW_REQ;
        T_ROW_REQ:  if (mem.req_ready) state <= T_ROW_WAIT;
        T_ROW_WAIT: if (mem.rvalid) state <= T_WRITE;
        T_WRITE:
        begin
          pix_idx <= pix_idx + 2'd1;
          if (pix_idx == 2'(`PIX_PER_WORD - 1))
          begin
            half <= !half;
            if (!half)
              state <= T_ROW_REQ;
            else if (tile_idx == 3'(`TILES_PER_LINE - 1))
            begin
              state     <= T_IDLE;
              fill_done <= 1'b1;
            end
            else
            begin
              // on to the next map entry
              tile_idx <= tile_idx + 3'd1;
              state    <= T_MAP_REQ;
            end
          end
        end
        default: state <= T_IDLE;
      endcase
    end
  end

  // same read data seen as map entry or as pixels
  always_ff @(posedge clk)
  begin
    if ((state == T_MAP_WAIT) && mem.rvalid)
      entry_q <= rd_word.ent;
    if ((state == T_ROW_WAIT) && mem.rvalid)
      word_q <= rd_word.bmp;
  end

endmodule

/* src/line_mixer.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module line_mixer import video_cfg_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                line_valid,
  output logic                line_ready,
  input  logic [7:0]          line_num,
  input  video_cfg_t          line_cfg,
  output logic                line_accept,
  output logic                fill_start,
  output logic [7:0]          fill_line,
  input  logic                gfx_done,
  input  logic                tile_done,
  input  logic                gfx_we,
  input  logic [5:0]          gfx_waddr,
  input  logic [`COLOR_W-1:0] gfx_wdata,
  input  logic                tile_we,
  input  logic [5:0]          tile_waddr,
  input  logic [`COLOR_W-1:0] tile_wdata,
  output logic                pix_valid,
  input  logic                pix_ready,
  output logic [`COLOR_W-1:0] pix_data,
  output logic                pix_last
);

  // ping-pong line banks per layer
  logic [`COLOR_W-1:0] gfx_mem  [2][`LINE_PIXELS];
  logic [`COLOR_W-1:0] tile_mem [2][`LINE_PIXELS];
  // per bank copy of what the mix needs
  logic [`COLOR_W-1:0] border_b [2];
  logic [1:0]          gfx_en_b;
  logic [1:0]          tile_en_b;

  logic                fill_bank;
  logic                drain_bank;
  logic                filling;
  logic                gfx_seen;
  logic                tile_seen;
  // bank holds a finished line not yet read out
  logic [1:0]          full;
  logic [5:0]          rd_idx;
  logic                fill_end;
  logic                load;
  logic                rd_end;
  logic [`COLOR_W-1:0] gfx_pix;
  logic [`COLOR_W-1:0] tile_pix;
  logic [`COLOR_W-1:0] mix_pix;

  // banks fill and drain in turn, so order is kept
  assign line_ready  = !filling && !full[fill_bank];
  assign line_accept = line_valid && line_ready;
  assign fill_end    = filling && (gfx_seen || gfx_done) && (tile_seen || tile_done);
  assign load        = (!pix_valid || pix_ready) && full[drain_bank];
  assign rd_end      = (rd_idx == 6'(`LINE_PIXELS - 1));

  // tile over gfx over border
  always_comb
  begin
    gfx_pix  = gfx_mem[drain_bank][rd_idx];
    tile_pix = tile_mem[drain_bank][rd_idx];
    if (tile_en_b[drain_bank] && (tile_pix != '0))
      mix_pix = tile_pix;
    else if (gfx_en_b[drain_bank])
      mix_pix = gfx_pix;
    else
      mix_pix = border_b[drain_bank];
  end

  always_ff @(posedge clk)
  begin
    if (gfx_we)
      gfx_mem[fill_bank][gfx_waddr] <= gfx_wdata;
    if (tile_we)
      tile_mem[fill_bank][tile_waddr] <= tile_wdata;
    // shadow config is valid from fill_start on
    if (fill_start)
    begin
      border_b[fill_bank]  <= line_cfg.border;
      gfx_en_b[fill_bank]  <= line_cfg.gfx_en;
      tile_en_b[fill_bank] <= line_cfg.tile_en;
    end
    if (line_accept)
      fill_line <= line_num;
    if (load)
      pix_data <= mix_pix;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fill_start <= 1'b0;
      filling    <= 1'b0;
      gfx_seen   <= 1'b0;
      tile_seen  <= 1'b0;
      fill_bank  <= 1'b0;
      drain_bank <= 1'b0;
      full       <= '0;
      rd_idx     <= '0;
      pix_valid  <= 1'b0;
      pix_last   <= 1'b0;
    end
    else
    begin
      fill_start <= line_accept;
      if (line_accept)
      begin
        filling   <= 1'b1;
        gfx_seen  <= 1'b0;
        tile_seen <= 1'b0;
      end
      else if (fill_end)
      begin
        // both layers written, hand the bank to the drain side
        filling         <= 1'b0;
        full[fill_bank] <= 1'b1;
        fill_bank       <= !fill_bank;
      end
      else
      begin
        if (gfx_done)
          gfx_seen <= 1'b1;
        if (tile_done)
          tile_seen <= 1'b1;
      end

      // output register, holds while stalled
      if (load)
      begin
        pix_valid <= 1'b1;
        pix_last  <= rd_end;
        rd_idx    <= rd_idx + 6'd1;
        if (rd_end)
        begin
          full[drain_bank] <= 1'b0;
          drain_bank       <= !drain_bank;
        end
      end
      else if (pix_ready)
        pix_valid <= 1'b0;
    end
  end

endmodule

/* src/video_line_top.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_line_top import video_cfg_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  // cpu register writes
  input  logic                cfg_wr,
  input  logic [`CFG_AW-1:0]  cfg_addr,
  input  logic [7:0]          cfg_data,
  // line requests
  input  logic                line_valid,
  output logic                line_ready,
  input  logic [7:0]          line_num,
  // external dram read port
  output logic                dram_valid,
  input  logic                dram_ready,
  output logic [`DRAM_AW-1:0] dram_addr,
  input  logic                dram_rvalid,
  input  logic [`DRAM_DW-1:0] dram_rdata,
  // pixel stream
  output logic                pix_valid,
  input  logic                pix_ready,
  output logic [`COLOR_W-1:0] pix_data,
  output logic                pix_last
);

  video_cfg_t          line_cfg;
  logic                line_accept;
  logic                fill_start;
  logic [7:0]          fill_line;
  logic                gfx_done;
  logic                tile_done;
  logic                gfx_we;
  logic [5:0]          gfx_waddr;
  logic [`COLOR_W-1:0] gfx_wdata;
  logic                tile_we;
  logic [5:0]          tile_waddr;
  logic [`COLOR_W-1:0] tile_wdata;

  // one requester link per fetcher
  dram_client_if gfx_if ();
  dram_client_if tile_if ();

  video_ports u_ports
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .line_accept (line_accept),
    .line_cfg    (line_cfg)
  );

  dram_arbiter u_arbiter
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .gfx         (gfx_if.arbiter),
    .tile        (tile_if.arbiter),
    .dram_valid  (dram_valid),
    .dram_ready  (dram_ready),
    .dram_addr   (dram_addr),
    .dram_rvalid (dram_rvalid),
    .dram_rdata  (dram_rdata)
  );

  gfx_fetch u_gfx
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem        (gfx_if.client),
    .line_cfg   (line_cfg),
    .fill_start (fill_start),
    .fill_line  (fill_line),
    .fill_done  (gfx_done),
    .gfx_we     (gfx_we),
    .gfx_waddr  (gfx_waddr),
    .gfx_wdata  (gfx_wdata)
  );

  tile_fetch u_tile
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem        (tile_if.client),
    .line_cfg   (line_cfg),
    .fill_start (fill_start),
    .fill_line  (fill_line),
    .fill_done  (tile_done),
    .tile_we    (tile_we),
    .tile_waddr (tile_waddr),
    .tile_wdata (tile_wdata)
  );

  line_mixer u_mixer
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .line_valid  (line_valid),
    .line_ready  (line_ready),
    .line_num    (line_num),
    .line_cfg    (line_cfg),
    .line_accept (line_accept),
    .fill_start  (fill_start),
    .fill_line   (fill_line),
    .gfx_done    (gfx_done),
    .tile_done   (tile_done),
    .gfx_we      (gfx_we),
    .gfx_waddr   (gfx_waddr),
    .gfx_wdata   (gfx_wdata),
    .tile_we     (tile_we),
    .tile_waddr  (tile_waddr),
    .tile_wdata  (tile_wdata),
    .pix_valid   (pix_valid),
    .pix_ready   (pix_ready),
    .pix_data    (pix_data),
    .pix_last    (pix_last)
  );

endmodule

/* tests/video_line_asserts.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_line_asserts
(
  input logic                clk,
  input logic                rst_n,
  input logic                dram_valid,
  input logic                dram_ready,
  input logic [`DRAM_AW-1:0] dram_addr,
  input logic                pix_valid,
  input logic                pix_ready,
  input logic [`COLOR_W-1:0] pix_data,
  input logic                pix_last
);

  // granted address holds under a port stall
  a_dram_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dram_valid && !dram_ready |=> $stable(dram_addr))
    else $error("dram_addr changed while stalled");

  // pixel stream holds under back-pressure
  a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid && !pix_ready |=> $stable(pix_data) && $stable(pix_last))
    else $error("pixel output changed while stalled");

  // quiet outputs right after reset
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !pix_valid && !dram_valid)
    else $error("valid output high after reset");

endmodule

bind video_line_top video_line_asserts u_asserts
(
  .clk        (clk),
  .rst_n      (rst_n),
  .dram_valid (dram_valid),
  .dram_ready (dram_ready),
  .dram_addr  (dram_addr),
  .pix_valid  (pix_valid),
  .pix_ready  (pix_ready),
  .pix_data   (pix_data),
  .pix_last   (pix_last)
);

/* tests/video_line_tb.sv */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_line_tb import video_cfg_pkg::*;
();

  localparam int PIX_TIMEOUT  = 3000;
  localparam int LINE_TIMEOUT = 30000;

  logic                clk;
  logic                rst_n;
  logic                cfg_wr;
  logic [`CFG_AW-1:0]  cfg_addr;
  logic [7:0]          cfg_data;
  logic                line_valid;
  logic                line_ready;
  logic [7:0]          line_num;
  logic                dram_valid;
  logic                dram_ready;
  logic [`DRAM_AW-1:0] dram_addr;
  logic                dram_rvalid;
  logic [`DRAM_DW-1:0] dram_rdata;
  logic                pix_valid;
  logic                pix_ready;
  logic [`COLOR_W-1:0] pix_data;
  logic                pix_last;

  // lazily filled dram contents
  logic [`DRAM_DW-1:0] dram_mem [bit [`DRAM_AW-1:0]];
  logic [31:0]         lcg_state = 32'd6;
  // accepted lines with their frozen config
  logic [7:0]          exp_line_q [$];
  video_cfg_t          exp_cfg_q [$];
  video_cfg_t          model_cfg;
  string               test_name;
  logic                stress;
  int                  dram_req_count;
  int                  pix_count;
  int                  resp_cnt;
  logic [`DRAM_AW-1:0] resp_addr;

  video_line_top UUT
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .line_valid  (line_valid),
    .line_ready  (line_ready),
    .line_num    (line_num),
    .dram_valid  (dram_valid),
    .dram_ready  (dram_ready),
    .dram_addr   (dram_addr),
    .dram_rvalid (dram_rvalid),
    .dram_rdata  (dram_rdata),
    .pix_valid   (pix_valid),
    .pix_ready   (pix_ready),
    .pix_data    (pix_data),
    .pix_last    (pix_last)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // first touch of an address gives it a random word
  function automatic logic [`DRAM_DW-1:0] mem_read(logic [`DRAM_AW-1:0] a);
    logic [31:0] r;
    if (!dram_mem.exists(a))
    begin
      r = lcg_next();
      dram_mem[a] = r[31:16];
    end
    return dram_mem[a];
  endfunction

  // reference model of one output pixel
  function automatic logic [7:0] expected_pixel(video_cfg_t c, logic [7:0] line, int idx);
    logic [15:0] w;
    logic [15:0] ent;
    logic [2:0]  x;
    logic [2:0]  sx;
    logic [2:0]  row;
    logic [3:0]  nib;
    logic [7:0]  gval;
    logic [7:0]  tval;
    gval = '0;
    tval = '0;
    if (c.gfx_en)
    begin
      // leftmost pixel in the top nibble
      w    = mem_read({c.vpage, line, 4'(idx / 4)});
      nib  = w[15 - 4 * (idx % 4) -: 4];
      gval = {c.palsel[3:0], nib};
    end
    if (c.tile_en)
    begin
      ent = mem_read({c.tmpage, 4'd0, line[7:3], 3'(idx / `TILE_PIXELS)});
      x   = 3'(idx % `TILE_PIXELS);
      // bit 10 x flip, bit 11 y flip
      sx  = ent[10] ? ~x : x;
      row = line[2:0] ^ {3{ent[11]}};
      w   = mem_read({c.tgpage, ent[7:0], row, sx[2]});
      nib = w[15 - 4 * int'(sx[1:0]) -: 4];
      if (nib != 4'd0)
        tval = {c.palsel[7:6], ent[9:8], nib};
    end
    if (c.tile_en && (tval != 8'd0))
      return tval;
    else if (c.gfx_en)
      return gval;
    else
      return c.border;
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_color(string name, logic [`COLOR_W-1:0] exp, logic [`COLOR_W-1:0] act);
    if (exp !== act)
      fail_now($sformatf("FAILED %s: expected %0h, actual %0h", name, exp, act));
  endtask

  task automatic check_last(string name, logic exp, logic act);
    if (exp !== act)
      fail_now($sformatf("FAILED %s: expected %0b, actual %0b", name, exp, act));
  endtask

  task automatic write_cfg(cfg_reg_e a, logic [7:0] d);
    cfg_wr   = 1'b1;
    cfg_addr = a;
    cfg_data = d;
    @(negedge clk);
    cfg_wr = 1'b0;
    case (a)
      VCONF:
      begin
        model_cfg.gfx_en  = d[0];
        model_cfg.tile_en = d[1];
      end
      BORDER:  model_cfg.border = d;
      PALSEL:  model_cfg.palsel = d;
      VPAGE:   model_cfg.vpage  = d;
      TMPAGE:  model_cfg.tmpage = d;
      TGPAGE:  model_cfg.tgpage = d;
      default: ;
    endcase
  endtask

  // hold the request until it is taken
  task automatic request_line(logic [7:0] n);
    int cnt;
    cnt        = 0;
    line_valid = 1'b1;
    line_num   = n;
    #1;
    while (!line_ready)
    begin
      @(negedge clk);
      #1;
      cnt++;
      if (cnt > LINE_TIMEOUT)
        fail_now("timeout waiting for line_ready");
    end
    exp_line_q.push_back(n);
    exp_cfg_q.push_back(model_cfg);
    @(negedge clk);
    line_valid = 1'b0;
  endtask

  task automatic wait_lines_done();
    int cnt;
    cnt = 0;
    while (exp_line_q.size() != 0)
    begin
      @(negedge clk);
      cnt++;
      if (cnt > LINE_TIMEOUT)
        fail_now("timeout waiting for lines to drain");
    end
  endtask

  // dram model and ready stalls, driven on the falling edge
  initial
  begin
    logic [31:0] r;
    forever
    begin
      @(negedge clk);
      r           = lcg_next();
      dram_ready  = stress ? (r[20:19] != 2'd0) : 1'b1;
      pix_ready   = stress ? (r[22:21] != 2'd0) : 1'b1;
      dram_rvalid = 1'b0;
      if (resp_cnt > 0)
      begin
        resp_cnt--;
        if (resp_cnt == 0)
        begin
          dram_rvalid = 1'b1;
          dram_rdata  = mem_read(resp_addr);
        end
      end
      #1;
      // request taken at the coming rising edge
      if (dram_valid && dram_ready)
      begin
        resp_addr = dram_addr;
        resp_cnt  = 1 + int'(r[25:24]);
        dram_req_count++;
      end
    end
  end

  // compare process, one queued line at a time
  initial
  begin
    logic [7:0] line;
    video_cfg_t c;
    int         wait_cnt;
    forever
    begin
      @(negedge clk);
      #2;
      if (exp_line_q.size() == 0)
      begin
        if (pix_valid)
          fail_now("pixel output with no line requested");
      end
      else
      begin
        line = exp_line_q[0];
        c    = exp_cfg_q[0];
        for (int idx = 0; idx < `LINE_PIXELS; idx++)
        begin
          if (idx != 0)
          begin
            @(negedge clk);
            #2;
          end
          wait_cnt = 0;
          while (!(pix_valid && pix_ready))
          begin
            @(negedge clk);
            #2;
            wait_cnt++;
            if (wait_cnt > PIX_TIMEOUT)
              fail_now("timeout waiting for a pixel");
          end
          check_color($sformatf("%s line %0d pixel %0d", test_name, line, idx),
                      expected_pixel(c, line, idx), pix_data);
          check_last($sformatf("%s line %0d last %0d", test_name, line, idx),
                     idx == `LINE_PIXELS - 1, pix_last);
          pix_count++;
        end
        void'(exp_line_q.pop_front());
        void'(exp_cfg_q.pop_front());
      end
    end
  end

  initial
  begin
    int reqs;
    int cnt;
    logic [31:0] r;
    rst_n          = 1'b0;
    cfg_wr         = 1'b0;
    cfg_addr       = '0;
    cfg_data       = '0;
    line_valid     = 1'b0;
    line_num       = '0;
    dram_ready     = 1'b1;
    dram_rvalid    = 1'b0;
    dram_rdata     = '0;
    pix_ready      = 1'b1;
    stress         = 1'b0;
    model_cfg      = '0;
    dram_req_count = 0;
    pix_count      = 0;
    resp_cnt       = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    test_name = "reset";
    @(negedge clk);
    #1;
    check_last("reset line_ready", 1'b1, line_ready);
    check_last("reset pix_valid", 1'b0, pix_valid);
    check_last("reset dram_valid", 1'b0, dram_valid);
    request_line(8'd0);
    wait_lines_done();

    test_name = "border";
    write_cfg(BORDER, 8'h5a);
    reqs = dram_req_count;
    request_line(8'd7);
    request_line(8'd40);
    wait_lines_done();
    if (dram_req_count != reqs)
      fail_now("dram request made with both layers off");

    test_name = "gfx";
    write_cfg(VPAGE, 8'h12);
    write_cfg(PALSEL, 8'hc3);
    write_cfg(VCONF, 8'h01);
    request_line(8'd0);
    request_line(8'd5);
    request_line(8'd17);
    request_line(8'd200);
    wait_lines_done();

    // random map entries carry random flips
    test_name = "tiles";
    write_cfg(TMPAGE, 8'h34);
    write_cfg(TGPAGE, 8'h56);
    write_cfg(VCONF, 8'h03);
    request_line(8'd3);
    request_line(8'd9);
    request_line(8'd130);
    request_line(8'd255);
    wait_lines_done();

    test_name = "stress";
    stress    = 1'b1;
    for (int i = 0; i < 6; i++)
    begin
      r = lcg_next();
      request_line(r[23:16]);
    end
    wait_lines_done();

    // tiles only, border shows through transparent pixels
    test_name = "cfg timing";
    write_cfg(VCONF, 8'h02);
    request_line(8'd66);
    cnt = 0;
    reqs = pix_count;
    while (pix_count < reqs + 10)
    begin
      @(negedge clk);
      cnt++;
      if (cnt > LINE_TIMEOUT)
        fail_now("timeout waiting for line output to start");
    end
    // rewrite colours while a line drains
    write_cfg(PALSEL, 8'h4e);
    write_cfg(BORDER, 8'ha7);
    request_line(8'd67);
    wait_lines_done();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* all.f */
+incdir+src
src/video_cfg_pkg.sv
src/video_mem_pkg.sv
src/dram_client_if.sv
src/video_ports.sv
src/dram_arbiter.sv
src/gfx_fetch.sv
src/tile_fetch.sv
src/line_mixer.sv
src/video_line_top.sv
tests/video_line_asserts.sv
tests/video_line_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module video_line_tb -o vsim &&
./obj_dir/vsim || exit 1
